// ==== src/ig_settings.svh ====
`ifndef IG_SETTINGS_SVH
`define IG_SETTINGS_SVH

// ----------------------------------------
// image geometry
// ----------------------------------------

// pixels per line, power of two from 4 to 256
`define IG_WIDTH 16

// lines per image, 2 or more
`define IG_HEIGHT 16

// ----------------------------------------
// data widths
// ----------------------------------------

`define IG_PIX_BITS 8
`define IG_COMP_BITS 10

`endif

// ==== src/ig_pkg.sv ====
`include "ig_settings.svh"

package ig_pkg;

    // ----------------------------------------
    // derived sizes
    // ----------------------------------------

    localparam int NUM_PIX = `IG_WIDTH * `IG_HEIGHT;
    localparam int ADDR_BITS = $clog2(NUM_PIX);

    // output position counters in the calculation stage
    localparam int COL_BITS = $clog2(`IG_WIDTH);
    localparam int ROW_BITS = $clog2(`IG_HEIGHT);

    // gx and gy side by side
    localparam int GRAD_BITS = 2 * `IG_COMP_BITS;

    // ----------------------------------------
    // gradient word
    // ----------------------------------------

    // comp is the datapath view, raw is the bus view
    typedef union packed {
        struct packed {
            logic signed [`IG_COMP_BITS-1:0] gx;
            logic signed [`IG_COMP_BITS-1:0] gy;
        } comp;
        logic [GRAD_BITS-1:0] raw;
    } grad_word_u;

endpackage

// ==== src/ig_pixel_fetch.sv ====
`timescale 1ns/1ns
`include "ig_settings.svh"

module ig_pixel_fetch (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start,
    input  logic [`IG_PIX_BITS-1:0]       img_dat_i,
    input  logic                          img_ack,
    input  logic                          pix_ready,
    output logic                          img_cyc,
    output logic                          img_stb,
    output logic                          img_we,
    output logic [ig_pkg::ADDR_BITS-1:0]  img_adr,
    output logic                          pix_valid,
    output logic [`IG_PIX_BITS-1:0]       pix_data
);
    import ig_pkg::*;

    localparam logic [ADDR_BITS-1:0] LAST_ADR = ADDR_BITS'(NUM_PIX - 1);

    // more addresses left to read in this image
    logic busy;
    logic read_fire;
    logic pix_fire;

    assign read_fire = img_stb && img_ack;
    assign pix_fire = pix_valid && pix_ready;

    // read only port, one classic cycle per pixel
    assign img_cyc = img_stb;
    assign img_we = 1'b0;

    // ----------------------------------------
    // raster read sequencer
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            img_stb <= 1'b0;
            img_adr <= '0;
            pix_valid <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
            img_stb <= 1'b1;
            img_adr <= '0;
            pix_valid <= 1'b0;
        end else begin
            if (read_fire) begin
                img_stb <= 1'b0;
                pix_valid <= 1'b1;
                if (img_adr == LAST_ADR) begin
                    busy <= 1'b0;
                end else begin
                    img_adr <= img_adr + 1'b1;
                end
            end
            // next read only once the held pixel is gone
            if (pix_fire) begin
                pix_valid <= 1'b0;
                img_stb <= busy;
            end
        end
    end

    // returned pixel, held until accepted
    always_ff @(posedge clk) begin
        if (read_fire) begin
            pix_data <= img_dat_i;
        end
    end

endmodule

// ==== src/ig_gradient_calc.sv ====
`timescale 1ns/1ns
`include "ig_settings.svh"

module ig_gradient_calc (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  logic                     pix_valid,
    input  logic [`IG_PIX_BITS-1:0]  pix_data,
    input  logic                     grad_ready,
    output logic                     pix_ready,
    output logic                     grad_valid,
    output ig_pkg::grad_word_u       grad_word
);
    import ig_pkg::*;

    localparam logic [COL_BITS-1:0] LAST_COL = COL_BITS'(`IG_WIDTH - 1);
    localparam logic [ROW_BITS-1:0] LAST_RUN_ROW = ROW_BITS'(`IG_HEIGHT - 2);
    localparam int EXT_BITS = `IG_COMP_BITS - `IG_PIX_BITS;

    // lb[0] is the newest pixel, together with pix_data this spans a line plus one
    logic [`IG_PIX_BITS-1:0] lb [`IG_WIDTH];

    // output position of the next word
    logic [COL_BITS-1:0] col_cnt;
    logic [ROW_BITS-1:0] row_cnt;

    // primed: first line is buffered, flushing: bottom row drains
    logic primed;
    logic flushing;

    logic out_free;
    logic pix_fire;
    logic flush_step;
    logic load_out;
    logic shift_en;
    logic last_col;

    logic signed [`IG_COMP_BITS-1:0] pix_ext;
    logic signed [`IG_COMP_BITS-1:0] right_ext;
    logic signed [`IG_COMP_BITS-1:0] below_ext;
    logic signed [`IG_COMP_BITS-1:0] dx;
    logic signed [`IG_COMP_BITS-1:0] dy;
    grad_word_u next_word;

    // ----------------------------------------
    // handshake
    // ----------------------------------------

    assign out_free = !grad_valid || grad_ready;
    assign pix_ready = !flushing && (!primed || out_free);
    assign pix_fire = pix_valid && pix_ready;
    assign flush_step = flushing && out_free;
    assign load_out = (primed && pix_fire) || flush_step;
    assign shift_en = pix_fire || flush_step;

    // ----------------------------------------
    // difference datapath
    // ----------------------------------------

    // pixel and its right neighbour sit at the old end of the buffer
    assign pix_ext = {{EXT_BITS{1'b0}}, lb[`IG_WIDTH-1]};
    assign right_ext = {{EXT_BITS{1'b0}}, lb[`IG_WIDTH-2]};
    assign below_ext = {{EXT_BITS{1'b0}}, pix_data};

    assign dx = right_ext - pix_ext;
    assign dy = below_ext - pix_ext;
    assign last_col = (col_cnt == LAST_COL);

    always_comb begin
        next_word.comp.gx = last_col ? '0 : dx;
        // no row below while flushing
        next_word.comp.gy = flushing ? '0 : dy;
    end

    // ----------------------------------------
    // position and phase control
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (reset || start) begin
            grad_valid <= 1'b0;
            primed <= 1'b0;
            flushing <= 1'b0;
            col_cnt <= '0;
            row_cnt <= '0;
        end else begin
            if (load_out) begin
                grad_valid <= 1'b1;
            end else if (grad_ready) begin
                grad_valid <= 1'b0;
            end

            // fill phase, col_cnt wraps back to 0 as the line completes
            if (pix_fire && !primed) begin
                col_cnt <= col_cnt + 1'b1;
                if (last_col) begin
                    primed <= 1'b1;
                end
            end

            if (load_out) begin
                col_cnt <= col_cnt + 1'b1;
                if (last_col) begin
                    if (flushing) begin
                        flushing <= 1'b0;
                        row_cnt <= '0;
                    end else if (row_cnt == LAST_RUN_ROW) begin
                        primed <= 1'b0;
                        flushing <= 1'b1;
                    end else begin
                        row_cnt <= row_cnt + 1'b1;
                    end
                end
            end
        end
    end

    // line buffer and output word
    always_ff @(posedge clk) begin
        if (shift_en) begin
            lb[0] <= pix_data;
            for (int i = 1; i < `IG_WIDTH; i++) begin
                lb[i] <= lb[i-1];
            end
        end
        if (load_out) begin
            grad_word <= next_word;
        end
    end

endmodule

// ==== src/ig_gradient_store.sv ====
`timescale 1ns/1ns

module ig_gradient_store (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start,
    input  logic                          grad_valid,
    input  ig_pkg::grad_word_u            grad_word,
    input  logic                          grad_ack,
    output logic                          grad_ready,
    output logic                          grad_cyc,
    output logic                          grad_stb,
    output logic                          grad_we,
    output logic [ig_pkg::ADDR_BITS-1:0]  grad_adr,
    output logic [ig_pkg::GRAD_BITS-1:0]  grad_dat_o,
    output logic                          done
);
    import ig_pkg::*;

    localparam logic [ADDR_BITS-1:0] LAST_ADR = ADDR_BITS'(NUM_PIX - 1);

    logic word_fire;
    logic write_fire;

    // one word at a time, free again the cycle after ack
    assign grad_ready = !grad_stb;
    assign word_fire = grad_valid && grad_ready;
    assign write_fire = grad_stb && grad_ack;

    // write only port
    assign grad_cyc = grad_stb;
    assign grad_we = 1'b1;

    // ----------------------------------------
    // write sequencer
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            grad_stb <= 1'b0;
            grad_adr <= '0;
            done <= 1'b0;
        end else begin
            if (word_fire) begin
                grad_stb <= 1'b1;
            end else if (write_fire) begin
                grad_stb <= 1'b0;
            end

            // grad_adr doubles as the write counter
            if (start) begin
                grad_adr <= '0;
                done <= 1'b0;
            end else if (write_fire) begin
                if (grad_adr == LAST_ADR) begin
                    done <= 1'b1;
                end else begin
                    grad_adr <= grad_adr + 1'b1;
                end
            end
        end
    end

    // write data through the raw view
    always_ff @(posedge clk) begin
        if (word_fire) begin
            grad_dat_o <= grad_word.raw;
        end
    end

endmodule

// ==== src/ig_top.sv ====
`timescale 1ns/1ns
`include "ig_settings.svh"

module ig_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start,
    // image memory, read only
    output logic                          img_cyc,
    output logic                          img_stb,
    output logic                          img_we,
    output logic [ig_pkg::ADDR_BITS-1:0]  img_adr,
    input  logic [`IG_PIX_BITS-1:0]       img_dat_i,
    input  logic                          img_ack,
    // gradient memory, write only
    output logic                          grad_cyc,
    output logic                          grad_stb,
    output logic                          grad_we,
    output logic [ig_pkg::ADDR_BITS-1:0]  grad_adr,
    output logic [ig_pkg::GRAD_BITS-1:0]  grad_dat_o,
    input  logic                          grad_ack,
    output logic                          done
);
    import ig_pkg::*;

    // fetch to calc
    logic                     pix_valid;
    logic [`IG_PIX_BITS-1:0]  pix_data;
    logic                     pix_ready;

    // calc to store
    logic                     grad_valid;
    grad_word_u               grad_word;
    logic                     grad_ready;

    // ----------------------------------------
    // stages
    // ----------------------------------------

    ig_pixel_fetch u_fetch (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .img_dat_i (img_dat_i),
        .img_ack   (img_ack),
        .pix_ready (pix_ready),
        .img_cyc   (img_cyc),
        .img_stb   (img_stb),
        .img_we    (img_we),
        .img_adr   (img_adr),
        .pix_valid (pix_valid),
        .pix_data  (pix_data)
    );

    ig_gradient_calc u_calc (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .pix_valid  (pix_valid),
        .pix_data   (pix_data),
        .grad_ready (grad_ready),
        .pix_ready  (pix_ready),
        .grad_valid (grad_valid),
        .grad_word  (grad_word)
    );

    ig_gradient_store u_store (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .grad_valid (grad_valid),
        .grad_word  (grad_word),
        .grad_ack   (grad_ack),
        .grad_ready (grad_ready),
        .grad_cyc   (grad_cyc),
        .grad_stb   (grad_stb),
        .grad_we    (grad_we),
        .grad_adr   (grad_adr),
        .grad_dat_o (grad_dat_o),
        .done       (done)
    );

endmodule

// ==== sim/ig_properties.sv ====
`timescale 1ns/1ns

module ig_properties (
    input logic                          clk,
    input logic                          reset,
    input logic                          start,
    input logic                          done,
    input logic                          img_cyc,
    input logic                          img_stb,
    input logic                          img_we,
    input logic [ig_pkg::ADDR_BITS-1:0]  img_adr,
    input logic                          img_ack,
    input logic                          grad_cyc,
    input logic                          grad_stb,
    input logic                          grad_we,
    input logic [ig_pkg::ADDR_BITS-1:0]  grad_adr,
    input logic [ig_pkg::GRAD_BITS-1:0]  grad_dat_o,
    input logic                          grad_ack
);
    import ig_pkg::*;

    // failed assertions so far
    int fail_count = 0;
    logic seen_start = 1'b0;
    logic idle;
    // finished reads and writes since the last start
    int rd_index = 0;
    int wr_count = 0;

    assign idle = !img_cyc && !img_stb && !grad_cyc && !grad_stb && !done;

    always @(posedge clk) begin
        if (reset) begin
            seen_start <= 1'b0;
            rd_index <= 0;
            wr_count <= 0;
        end else if (start) begin
            seen_start <= 1'b1;
            rd_index <= 0;
            wr_count <= 0;
        end else begin
            if (img_stb && img_ack) begin
                rd_index <= rd_index + 1;
            end
            if (grad_stb && grad_ack) begin
                wr_count <= wr_count + 1;
            end
        end
    end

    task automatic count_failure(input string what);
        fail_count++;
        $error("%s", what);
    endtask

    // ----------------------------------------
    // reset and bus rules
    // ----------------------------------------

    idle_in_reset: assert property (@(posedge clk) reset |=> idle)
        else count_failure("bus or done active after reset");
    idle_before_start: assert property (@(posedge clk) (!reset && !seen_start) |-> idle)
        else count_failure("bus or done active before the first start");
    stb_needs_cyc: assert property (@(posedge clk) disable iff (reset)
        (!img_stb || img_cyc) && (!grad_stb || grad_cyc))
        else count_failure("stb high without cyc");
    img_read_only: assert property (@(posedge clk) disable iff (reset) img_stb |-> !img_we)
        else count_failure("write enable high on the image port");
    grad_write_only: assert property (@(posedge clk) disable iff (reset) grad_stb |-> grad_we)
        else count_failure("write enable low on the gradient port");
    hold_img: assert property (@(posedge clk) disable iff (reset)
        (img_stb && !img_ack) |=> (img_stb && $stable(img_adr) && $stable(img_we)))
        else count_failure("image read changed before ack");
    hold_grad: assert property (@(posedge clk) disable iff (reset)
        (grad_stb && !grad_ack) |=> (grad_stb && $stable(grad_adr) && $stable(grad_we)
        && $stable(grad_dat_o)))
        else count_failure("gradient write changed before ack");

    // ----------------------------------------
    // ordering and completion
    // ----------------------------------------

    read_order: assert property (@(posedge clk) disable iff (reset)
        (img_stb && img_ack) |-> (int'(img_adr) == rd_index))
        else count_failure("image read out of raster order or repeated");
    done_after_all: assert property (@(posedge clk) disable iff (reset)
        $rose(done) |-> (wr_count == NUM_PIX && rd_index == NUM_PIX))
        else count_failure("done rose before every pixel was read and written");
    start_clears_done: assert property (@(posedge clk) disable iff (reset) start |=> !done)
        else count_failure("done still high after start");

endmodule

// ==== sim/ig_tb.sv ====
`timescale 1ns/1ns
`include "ig_settings.svh"

module ig_tb;
    import ig_pkg::*;

    localparam int W = `IG_WIDTH;
    localparam int H = `IG_HEIGHT;
    // 8 x pixels x 4 cycles for each of two images
    localparam int TIMEOUT_CYCLES = 8 * NUM_PIX * 4 * 2;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic start = 1'b0;
    logic img_cyc;
    logic img_stb;
    logic img_we;
    logic [ADDR_BITS-1:0] img_adr;
    logic [`IG_PIX_BITS-1:0] img_dat_i = '0;
    logic img_ack = 1'b0;
    logic grad_cyc;
    logic grad_stb;
    logic grad_we;
    logic [ADDR_BITS-1:0] grad_adr;
    logic [GRAD_BITS-1:0] grad_dat_o;
    logic grad_ack = 1'b0;
    logic done;

    logic [`IG_PIX_BITS-1:0] img_mem [NUM_PIX];
    logic [GRAD_BITS-1:0] grad_mem [NUM_PIX];
    int write_count [NUM_PIX];

    int seed = 4;
    int img_wait = 0;
    int grad_wait = 0;
    int errors = 0;
    int cycle_count = 0;

    ig_top uut (.*);

    bind ig_top ig_properties props (
        .clk, .reset, .start, .done,
        .img_cyc, .img_stb, .img_we, .img_adr, .img_ack,
        .grad_cyc, .grad_stb, .grad_we, .grad_adr, .grad_dat_o, .grad_ack
    );

    always #4 clk = ~clk;

    // ----------------------------------------
    // memory models with 0 to 2 wait cycles
    // ----------------------------------------

    always @(posedge clk) begin
        if (reset || img_ack) begin
            img_ack <= 1'b0;
        end else if (img_cyc && img_stb) begin
            if (img_wait == 0) begin
                img_ack <= 1'b1;
                img_dat_i <= img_mem[img_adr];
                img_wait <= $unsigned($random(seed)) % 3;
            end else begin
                img_wait <= img_wait - 1;
            end
        end
        if (reset || grad_ack) begin
            grad_ack <= 1'b0;
        end else if (grad_cyc && grad_stb) begin
            if (grad_wait == 0) begin
                grad_ack <= 1'b1;
                grad_mem[grad_adr] <= grad_dat_o;
                write_count[grad_adr] <= write_count[grad_adr] + 1;
                grad_wait <= $unsigned($random(seed)) % 3;
            end else begin
                grad_wait <= grad_wait - 1;
            end
        end
        // fresh write counts for every image
        if (start) begin
            for (int a = 0; a < NUM_PIX; a++) begin
                write_count[a] <= 0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: done did not rise within %0d cycles", TIMEOUT_CYCLES);
            $display("summary: %0d value errors, %0d property failures",
                errors, uut.props.fail_count);
            $display("Simulation failed");
            $finish;
        end
    end

    // ----------------------------------------
    // stimulus and checks
    // ----------------------------------------

    task automatic fill_image();
        int r;
        for (int a = 0; a < NUM_PIX; a++) begin
            r = $random(seed);
            img_mem[a] = r[`IG_PIX_BITS-1:0];
        end
    endtask

    // neighbour differences with zero at the far border
    function automatic logic [GRAD_BITS-1:0] expected_word(input int a);
        int dx;
        int dy;
        dx = 0;
        dy = 0;
        if (a % W < W - 1) begin
            dx = int'(img_mem[a + 1]) - int'(img_mem[a]);
        end
        if (a / W < H - 1) begin
            dy = int'(img_mem[a + W]) - int'(img_mem[a]);
        end
        return {dx[`IG_COMP_BITS-1:0], dy[`IG_COMP_BITS-1:0]};
    endfunction

    task automatic check_gradients(input string name);
        logic [GRAD_BITS-1:0] want;
        for (int a = 0; a < NUM_PIX; a++) begin
            want = expected_word(a);
            assert (write_count[a] == 1) else begin
                $display("FAIL %s write count at %0d: expected 1, actual %0d",
                    name, a, write_count[a]);
                errors++;
            end
            assert (grad_mem[a] === want) else begin
                $display("FAIL %s word at %0d: expected %h, actual %h",
                    name, a, want, grad_mem[a]);
                errors++;
            end
        end
    endtask

    task automatic run_image(input string name);
        fill_image();
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        while (!done) begin
            @(posedge clk);
        end
        check_gradients(name);
    endtask

    initial begin
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        run_image("image 1");
        run_image("image 2");
        $display("summary: %0d value errors, %0d property failures",
            errors, uut.props.fail_count);
        if (errors == 0 && uut.props.fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+src
src/ig_pkg.sv
src/ig_pixel_fetch.sv
src/ig_gradient_calc.sv
src/ig_gradient_store.sv
src/ig_top.sv
sim/ig_properties.sv
sim/ig_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = ig_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
RUN_OPTS  = +verilator+error+limit+1000
FAIL_MSG  = Simulation failed
PASS_MSG  = Simulation passed

SOURCES = $(wildcard src/*.sv src/*.svh sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_OPTS) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAILED, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no result line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
